//--- common/bp_cfg.svh
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// Instruction address width
`define BP_XLEN 32

// BTB index bits, taken from the PC just above the byte offset
`define BP_INDEX_WIDTH 6

// Global history length, also the PHT index width
`define BP_HISTORY_WIDTH 4

// Fetch address after reset
`define BP_RESET_PC 32'h0000_0000

`endif

//--- common/bp_pkg.sv
`include "bp_cfg.svh"

package bp_pkg;

    // One instruction address
    typedef logic [`BP_XLEN-1:0] pc_t;

    // Global branch history, newest outcome in bit 0
    typedef logic [`BP_HISTORY_WIDTH-1:0] ghr_t;

    // 2-bit saturating counter
    // Upper bit set means predict taken
    typedef logic [1:0] counter_t;

    // PC bits above the BTB index and the byte offset
    typedef logic [`BP_XLEN-`BP_INDEX_WIDTH-3:0] btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        pc_t      target;
    } btb_entry_t;

    // Sources for the next fetch address
    typedef enum logic [1:0] {
        NEXT_SEQ         = 2'b00,
        NEXT_RES_FALL    = 2'b01,
        NEXT_PRED_TARGET = 2'b10,
        NEXT_RES_TARGET  = 2'b11
    } next_sel_e;

endpackage

//--- predictor/pred_table.sv
`timescale 1ns/1ps

module pred_table #(
    parameter type    entry_t     = logic,
    parameter int     DEPTH_BITS  = 4,
    parameter entry_t RESET_ENTRY = entry_t'('0)
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [DEPTH_BITS-1:0] rd_idx_i,
    output entry_t                rd_data_o,
    input  logic                  wr_en_i,
    input  logic [DEPTH_BITS-1:0] wr_idx_i,
    input  entry_t                wr_data_i,
    output entry_t                wr_cur_o
);

    localparam int DEPTH = 1 << DEPTH_BITS;

    entry_t mem_q [DEPTH];

    // Lookup port for fetch
    assign rd_data_o = mem_q[rd_idx_i];

    // Entry currently held at the write slot feeds read-modify-write
    assign wr_cur_o = mem_q[wr_idx_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= RESET_ENTRY;
            end
        end else if (wr_en_i) begin
            mem_q[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

//--- predictor/gshare_predictor.sv
`timescale 1ns/1ps

`include "bp_cfg.svh"

module gshare_predictor (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  bp_pkg::pc_t       fetch_pc_i,
    input  logic              res_valid_i,
    input  bp_pkg::pc_t       res_pc_i,
    input  bp_pkg::pc_t       res_target_i,
    input  logic              res_taken_i,
    input  logic              res_pred_taken_i,
    input  bp_pkg::ghr_t      res_ghr_i,
    output logic              pred_taken_o,
    output bp_pkg::pc_t       pred_target_o,
    output bp_pkg::ghr_t      ghr_o,
    output logic              flush_o,
    output bp_pkg::next_sel_e next_sel_o
);
    import bp_pkg::*;

    localparam int HW = `BP_HISTORY_WIDTH;
    localparam int IW = `BP_INDEX_WIDTH;

    // Counters start weakly not-taken and the BTB starts empty
    localparam counter_t   PHT_RESET = 2'b01;
    localparam btb_entry_t BTB_RESET = '0;

    ghr_t          ghr_q;

    logic [HW-1:0] pht_rd_idx;
    logic [HW-1:0] pht_wr_idx;
    counter_t      pht_rd_cnt;
    counter_t      pht_cur_cnt;
    counter_t      pht_next_cnt;

    logic [IW-1:0] btb_rd_idx;
    logic [IW-1:0] btb_wr_idx;
    btb_entry_t    btb_rd_entry;
    btb_entry_t    btb_cur_entry;
    btb_entry_t    btb_new_entry;
    logic          btb_wr_en;
    logic          btb_hit;

    logic          mispredict;

    // Global history shifts in every resolved outcome
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ghr_q <= '0;
        end else if (res_valid_i) begin
            ghr_q <= {ghr_q[HW-2:0], res_taken_i};
        end
    end

    assign ghr_o = ghr_q;

    // Gshare hashing
    // Fetch side uses the live history and update side the one that travelled
    assign pht_rd_idx = fetch_pc_i[HW+1:2] ^ ghr_q;
    assign pht_wr_idx = res_pc_i[HW+1:2] ^ res_ghr_i;

    // Step toward the resolved outcome and saturate at both ends
    always_comb begin
        pht_next_cnt = pht_cur_cnt;
        if (res_taken_i) begin
            if (pht_cur_cnt != 2'b11) begin
                pht_next_cnt = pht_cur_cnt + 2'b01;
            end
        end else if (pht_cur_cnt != 2'b00) begin
            pht_next_cnt = pht_cur_cnt - 2'b01;
        end
    end

    pred_table #(
        .entry_t     (counter_t),
        .DEPTH_BITS  (HW),
        .RESET_ENTRY (PHT_RESET)
    ) u_pht (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (pht_rd_idx),
        .rd_data_o (pht_rd_cnt),
        .wr_en_i   (res_valid_i),
        .wr_idx_i  (pht_wr_idx),
        .wr_data_i (pht_next_cnt),
        .wr_cur_o  (pht_cur_cnt)
    );

    // BTB is direct mapped on the PC bits above the byte offset
    assign btb_rd_idx = fetch_pc_i[IW+1:2];
    assign btb_wr_idx = res_pc_i[IW+1:2];

    assign btb_new_entry.valid  = 1'b1;
    assign btb_new_entry.tag    = res_pc_i[`BP_XLEN-1:IW+2];
    assign btb_new_entry.target = res_target_i;

    // Only taken branches allocate
    // A slot already holding the same entry is left alone
    assign btb_wr_en = res_valid_i && res_taken_i && (btb_cur_entry != btb_new_entry);

    pred_table #(
        .entry_t     (btb_entry_t),
        .DEPTH_BITS  (IW),
        .RESET_ENTRY (BTB_RESET)
    ) u_btb (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .rd_idx_i  (btb_rd_idx),
        .rd_data_o (btb_rd_entry),
        .wr_en_i   (btb_wr_en),
        .wr_idx_i  (btb_wr_idx),
        .wr_data_i (btb_new_entry),
        .wr_cur_o  (btb_cur_entry)
    );

    assign btb_hit = btb_rd_entry.valid
                     && (btb_rd_entry.tag == fetch_pc_i[`BP_XLEN-1:IW+2]);

    // Taken only when the target is known and the counter agrees
    assign pred_taken_o  = btb_hit && pht_rd_cnt[1];
    assign pred_target_o = btb_rd_entry.target;

    // Targets are static so only the direction can be wrong
    assign mispredict = res_valid_i && (res_taken_i != res_pred_taken_i);
    assign flush_o    = mispredict;

    // Resolution beats prediction and prediction beats sequential
    always_comb begin
        if (mispredict && res_taken_i) begin
            next_sel_o = NEXT_RES_TARGET;
        end else if (mispredict) begin
            next_sel_o = NEXT_RES_FALL;
        end else if (pred_taken_o) begin
            next_sel_o = NEXT_PRED_TARGET;
        end else begin
            next_sel_o = NEXT_SEQ;
        end
    end

endmodule

//--- design/fetch_frontend.sv
`timescale 1ns/1ps

`include "bp_cfg.svh"

module fetch_frontend (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  logic         stall_i,
    input  logic         res_valid_i,
    input  bp_pkg::pc_t  res_pc_i,
    input  bp_pkg::pc_t  res_target_i,
    input  logic         res_taken_i,
    input  logic         res_pred_taken_i,
    input  bp_pkg::ghr_t res_ghr_i,
    output bp_pkg::pc_t  pc_o,
    output logic         pred_taken_o,
    output bp_pkg::ghr_t ghr_o,
    output logic         flush_o
);
    import bp_pkg::*;

    pc_t       pc_q;
    pc_t       pc_next;
    pc_t       pc_plus4;
    pc_t       res_fall;
    pc_t       pred_target;
    next_sel_e next_sel;
    logic      pc_we;

    gshare_predictor u_gshare_predictor (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .fetch_pc_i       (pc_q),
        .res_valid_i      (res_valid_i),
        .res_pc_i         (res_pc_i),
        .res_target_i     (res_target_i),
        .res_taken_i      (res_taken_i),
        .res_pred_taken_i (res_pred_taken_i),
        .res_ghr_i        (res_ghr_i),
        .pred_taken_o     (pred_taken_o),
        .pred_target_o    (pred_target),
        .ghr_o            (ghr_o),
        .flush_o          (flush_o),
        .next_sel_o       (next_sel)
    );

    // Sequential path and fall-through of the resolved branch
    assign pc_plus4 = pc_q + pc_t'(4);
    assign res_fall = res_pc_i + pc_t'(4);

    always_comb begin
        case (next_sel)
            NEXT_SEQ:         pc_next = pc_plus4;
            NEXT_RES_FALL:    pc_next = res_fall;
            NEXT_PRED_TARGET: pc_next = pred_target;
            NEXT_RES_TARGET:  pc_next = res_target_i;
            default:          pc_next = pc_plus4;
        endcase
    end

    // A redirect must land even while the pipeline is stalled
    assign pc_we = !stall_i || flush_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pc_q <= `BP_RESET_PC;
        end else if (pc_we) begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release on a falling edge away from the active edge
    initial begin
        rst_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

//--- verification/fetch_frontend_asserts.sv
`timescale 1ns/1ps

`include "bp_cfg.svh"

module fetch_frontend_asserts (
    input logic        clk_i,
    input logic        rst_ni,
    input logic        stall_i,
    input logic        res_valid_i,
    input logic        flush_i,
    input bp_pkg::pc_t pc_i
);

    int assert_fails = 0;

    // A flush only comes from a resolved branch
    flush_needs_resolve: assert property (
        @(posedge clk_i) disable iff (!rst_ni) flush_i |-> res_valid_i
    ) else begin
        assert_fails++;
        $error("flush_o high without res_valid_i");
    end

    // Stall freezes fetch unless a redirect is pending
    stall_holds_pc: assert property (
        @(posedge clk_i) disable iff (!rst_ni) (stall_i && !flush_i) |=> $stable(pc_i)
    ) else begin
        assert_fails++;
        $error("pc_o moved during a stall without a flush");
    end

    reset_pc_value: assert property (
        @(posedge clk_i) $rose(rst_ni) |-> (pc_i == `BP_RESET_PC)
    ) else begin
        assert_fails++;
        $error("pc_o is not the reset PC right after reset");
    end

endmodule

//--- verification/fetch_frontend_tb.sv
`timescale 1ns/1ps

`include "bp_cfg.svh"

module fetch_frontend_tb;
    import bp_pkg::*;

    localparam int HW                  = `BP_HISTORY_WIDTH;
    localparam int IW                  = `BP_INDEX_WIDTH;
    localparam int PHT_DEPTH           = 1 << HW;
    localparam int BTB_DEPTH           = 1 << IW;
    localparam int CLK_PERIOD_NS       = 10;
    localparam int FETCH_LIMIT         = 64;
    localparam int DIRECTED_MAX_CYCLES = 300;
    localparam int RANDOM_CYCLES       = 400;
    // Twice the longest possible run including reset
    localparam int WATCHDOG_NS = 2 * CLK_PERIOD_NS * (DIRECTED_MAX_CYCLES + RANDOM_CYCLES + 4);

    // A backward loop branch and a helper branch
    localparam pc_t LOOP_BR  = 32'h0000_0240;
    localparam pc_t LOOP_TGT = 32'h0000_0220;
    localparam pc_t AUX_BR   = 32'h0000_0404;
    localparam pc_t AUX_TGT  = 32'h0000_0230;

    logic clk;
    logic rst_n;
    logic stall;
    logic res_valid;
    pc_t  res_pc;
    pc_t  res_target;
    logic res_taken;
    logic res_pred_taken;
    ghr_t res_ghr;
    pc_t  pc;
    logic pred_taken;
    ghr_t ghr;
    logic flush;

    // Reference model state
    pc_t      m_pc;
    ghr_t     m_ghr;
    counter_t m_pht [PHT_DEPTH];
    logic     m_btb_valid [BTB_DEPTH];
    btb_tag_t m_btb_tag [BTB_DEPTH];
    pc_t      m_btb_target [BTB_DEPTH];

    // What the pipeline recorded at the last fetch
    pc_t  seen_pc;
    logic seen_pred;
    ghr_t seen_ghr;
    logic seen_flush;

    int seed;

    tb_clock_gen u_tb_clock_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    fetch_frontend u_fetch_frontend (
        .clk_i            (clk),
        .rst_ni           (rst_n),
        .stall_i          (stall),
        .res_valid_i      (res_valid),
        .res_pc_i         (res_pc),
        .res_target_i     (res_target),
        .res_taken_i      (res_taken),
        .res_pred_taken_i (res_pred_taken),
        .res_ghr_i        (res_ghr),
        .pc_o             (pc),
        .pred_taken_o     (pred_taken),
        .ghr_o            (ghr),
        .flush_o          (flush)
    );

    bind fetch_frontend fetch_frontend_asserts u_fetch_frontend_asserts (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .stall_i     (stall_i),
        .res_valid_i (res_valid_i),
        .flush_i     (flush_o),
        .pc_i        (pc_o)
    );

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic stop_on_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_pc(input string what, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_ghr(input string what, input ghr_t got, input ghr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_failure();
        end
    endtask

    // Static target per branch within a small code region
    function automatic pc_t target_of(input pc_t br);
        return (br ^ 32'h0000_0150) & 32'h0000_03FC;
    endfunction

    // One cycle from falling edge to falling edge checked against the model
    task automatic step_cycle(input logic st, input logic rv, input pc_t rpc,
                              input pc_t rtgt, input logic rtk, input logic rpred,
                              input ghr_t rghr);
        logic [IW-1:0] bidx;
        logic [HW-1:0] ridx;
        logic [HW-1:0] widx;
        logic          exp_pred;
        logic          exp_flush;
        pc_t           exp_next;

        stall          = st;
        res_valid      = rv;
        res_pc         = rpc;
        res_target     = rtgt;
        res_taken      = rtk;
        res_pred_taken = rpred;
        res_ghr        = rghr;
        #1;
        bidx      = m_pc[IW+1:2];
        ridx      = m_pc[HW+1:2] ^ m_ghr;
        exp_pred  = m_btb_valid[bidx] && (m_btb_tag[bidx] == m_pc[`BP_XLEN-1:IW+2])
                    && m_pht[ridx][1];
        exp_flush = rv && (rtk != rpred);
        check_pc("pc_o", pc, m_pc);
        check_ghr("ghr_o", ghr, m_ghr);
        check_bit("pred_taken_o", pred_taken, exp_pred);
        check_bit("flush_o", flush, exp_flush);
        seen_pc    = pc;
        seen_pred  = pred_taken;
        seen_ghr   = ghr;
        seen_flush = flush;

        if (exp_flush && rtk)
            exp_next = rtgt;
        else if (exp_flush)
            exp_next = rpc + 32'd4;
        else if (exp_pred)
            exp_next = m_btb_target[bidx];
        else
            exp_next = m_pc + 32'd4;
        if (!st || exp_flush)
            m_pc = exp_next;

        // Resolution updates land on the coming edge
        if (rv) begin
            widx = rpc[HW+1:2] ^ rghr;
            if (rtk && m_pht[widx] != 2'b11)
                m_pht[widx] = m_pht[widx] + 2'b01;
            else if (!rtk && m_pht[widx] != 2'b00)
                m_pht[widx] = m_pht[widx] - 2'b01;
            if (rtk) begin
                m_btb_valid[rpc[IW+1:2]]  = 1'b1;
                m_btb_tag[rpc[IW+1:2]]    = rpc[`BP_XLEN-1:IW+2];
                m_btb_target[rpc[IW+1:2]] = rtgt;
            end
            m_ghr = {m_ghr[HW-2:0], rtk};
        end
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n, input logic st);
        repeat (n) step_cycle(st, 1'b0, '0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic resolve_branch(input pc_t rpc, input pc_t rtgt, input logic rtk,
                                  input logic rpred, input ghr_t rghr);
        step_cycle(1'b0, 1'b1, rpc, rtgt, rtk, rpred, rghr);
    endtask

    task automatic fetch_until(input pc_t target);
        int n;

        n = 0;
        while (m_pc != target && n < FETCH_LIMIT) begin
            idle_cycles(1, 1'b0);
            n++;
        end
        if (m_pc != target) begin
            $display("Fetch did not reach 0x%h within %0d cycles", target, FETCH_LIMIT);
            stop_on_failure();
        end
    endtask

    task automatic test_sequential_and_stall();
        check_pc("pc_o after reset", pc, `BP_RESET_PC);
        idle_cycles(5, 1'b0);
        check_pc("pc_o after five fetches", pc, `BP_RESET_PC + 32'd20);
        idle_cycles(3, 1'b1);
        check_pc("pc_o during stall", pc, `BP_RESET_PC + 32'd20);
        idle_cycles(2, 1'b0);
        check_pc("pc_o after stall", pc, `BP_RESET_PC + 32'd28);
    endtask

    task automatic test_unpredicted_taken();
        ghr_t hist_before;

        hist_before = m_ghr;
        idle_cycles(1, 1'b0);
        resolve_branch(32'h0000_0100, 32'h0000_0200, 1'b1, 1'b0, seen_ghr);
        check_pc("pc_o after redirect", pc, 32'h0000_0200);
        check_ghr("ghr_o after taken", ghr, {hist_before[HW-2:0], 1'b1});
    endtask

    task automatic test_train_and_predict();
        ghr_t hist;

        // History that fetch sees once both outcomes are shifted in
        hist = {m_ghr[HW-3:0], 2'b11};
        resolve_branch(LOOP_BR, LOOP_TGT, 1'b1, 1'b0, hist);
        resolve_branch(LOOP_BR, LOOP_TGT, 1'b1, 1'b0, hist);
        check_ghr("ghr_o after training", ghr, hist);
        check_pc("pc_o after training", pc, LOOP_TGT);
        fetch_until(LOOP_BR);
        idle_cycles(1, 1'b0);
        check_bit("pred_taken_o at trained branch", seen_pred, 1'b1);
        check_pc("pc_o after predicted taken", pc, LOOP_TGT);
    endtask

    task automatic test_taken_mispredict();
        ghr_t hist;

        fetch_until(LOOP_BR);
        idle_cycles(1, 1'b0);
        check_bit("pred_taken_o before mispredict", seen_pred, 1'b1);
        hist = seen_ghr;
        idle_cycles(2, 1'b0);
        resolve_branch(LOOP_BR, LOOP_TGT, 1'b0, 1'b1, hist);
        check_pc("pc_o after fall-through redirect", pc, LOOP_BR + 32'd4);
        // Younger copy of the loop branch predicted right
        resolve_branch(LOOP_BR, LOOP_TGT, 1'b0, 1'b0, hist);
        // Three taken outcomes rebuild the history and the last one redirects
        resolve_branch(AUX_BR, AUX_TGT, 1'b1, 1'b1, '0);
        resolve_branch(AUX_BR, AUX_TGT, 1'b1, 1'b1, '0);
        resolve_branch(AUX_BR, AUX_TGT, 1'b1, 1'b0, '0);
        check_ghr("ghr_o rebuilt", ghr, hist);
        fetch_until(LOOP_BR);
        idle_cycles(1, 1'b0);
        check_bit("pred_taken_o after two decrements", seen_pred, 1'b0);
        check_pc("pc_o after not-taken prediction", pc, LOOP_BR + 32'd4);
    endtask

    task automatic test_random_stream();
        pc_t  q_pc [$];
        logic q_pred [$];
        ghr_t q_ghr [$];
        int   r;
        logic st;
        logic rv;
        logic rtk;
        pc_t  rpc;
        logic rpred;
        ghr_t rghr;

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r     = $random(seed);
            st    = (r[2:0] == 3'd0);
            rv    = (q_pc.size() >= 4) || ((q_pc.size() >= 2) && r[3]);
            rtk   = (r[5:4] != 2'd0);
            rpc   = '0;
            rpred = 1'b0;
            rghr  = '0;
            if (rv) begin
                rpc   = q_pc.pop_front();
                rpred = q_pred.pop_front();
                rghr  = q_ghr.pop_front();
            end
            step_cycle(st, rv, rpc, target_of(rpc), rtk, rpred, rghr);
            if (seen_flush) begin
                // Everything younger than the branch is squashed
                q_pc.delete();
                q_pred.delete();
                q_ghr.delete();
            end else if (!st) begin
                q_pc.push_back(seen_pc);
                q_pred.push_back(seen_pred);
                q_ghr.push_back(seen_ghr);
            end
        end
    endtask

    initial begin
        seed           = 83082;
        stall          = 1'b0;
        res_valid      = 1'b0;
        res_pc         = '0;
        res_target     = '0;
        res_taken      = 1'b0;
        res_pred_taken = 1'b0;
        res_ghr        = '0;
        m_pc           = `BP_RESET_PC;
        m_ghr          = '0;
        for (int i = 0; i < PHT_DEPTH; i++) begin
            m_pht[i] = 2'b01;
        end
        for (int i = 0; i < BTB_DEPTH; i++) begin
            m_btb_valid[i]  = 1'b0;
            m_btb_tag[i]    = '0;
            m_btb_target[i] = '0;
        end

        @(posedge rst_n);
        test_sequential_and_stall();
        test_unpredicted_taken();
        test_train_and_predict();
        test_taken_mispredict();
        test_random_stream();

        if (u_fetch_frontend.u_fetch_frontend_asserts.assert_fails == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("Assertion checks failed during the run");
            $display("TESTS FAILED");
            $fatal(1, "run ended with failures");
        end
    end

endmodule

//--- all.f
+incdir+common
common/bp_pkg.sv
predictor/pred_table.sv
predictor/gshare_predictor.sv
design/fetch_frontend.sv
verification/tb_clock_gen.sv
verification/fetch_frontend_asserts.sv
verification/fetch_frontend_tb.sv

//--- Makefile
# Verilator build and run for the fetch front end testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 --timescale 1ns/1ps

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
